// ==== source/board_pkg.sv ====
`default_nettype none

package board_pkg;

  // board resources
  localparam int NUM_LEDS = 8;
  localparam int NUM_BTNS = 7;

  // vga dac on the gp header
  localparam int COLOR_DEPTH = 6;
  localparam int GP_WIDTH    = 28;

  // button roles
  localparam int BTN_READY = 0;
  localparam int BTN_NEXT  = 1;
  localparam int BTN_PREV  = 2;

endpackage

`default_nettype wire

// ==== source/video_pkg.sv ====
`default_nettype none

package video_pkg;

  typedef enum logic [1:0] {
    PAT_BARS,
    PAT_GRAD,
    PAT_CHECK,
    PAT_SCROLL
  } pattern_e;

  // timing at one pixel, syncs are active low
  typedef struct packed {
    logic        hs;
    logic        vs;
    logic        active;
    logic        frame_start;
    logic [10:0] x;
    logic [10:0] y;
  } vid_timing_t;

  typedef struct packed {
    logic [board_pkg::COLOR_DEPTH-1:0] r;
    logic [board_pkg::COLOR_DEPTH-1:0] g;
    logic [board_pkg::COLOR_DEPTH-1:0] b;
  } rgb_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic active;
    rgb_t rgb;
  } pixel_t;

endpackage

`default_nettype wire

// ==== source/reset_stretch.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
  parameter int RESET_CYCLES = 16
) (
  input  wire  clk_25mhz,
  input  wire  rst_n,
  input  logic ready,
  output logic design_rst_n
);

  localparam int CW = $clog2(RESET_CYCLES + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      cnt          <= CW'(RESET_CYCLES);
      design_rst_n <= 1'b0;
    end else if (!ready) begin
      // hold while the ready button is released
      cnt          <= CW'(RESET_CYCLES);
      design_rst_n <= 1'b0;
    end else if (cnt != '0) begin
      cnt          <= cnt - 1'b1;
      design_rst_n <= (cnt == CW'(1));
    end else begin
      design_rst_n <= 1'b1;
    end
  end

  // release only after ready was high for the whole stretch
  a_no_release_unready: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n)
    $rose(design_rst_n) |-> $past(ready) && $past(ready, RESET_CYCLES)
  );

endmodule

`default_nettype wire

// ==== source/btn_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module btn_ctrl (
  input  wire                            clk_25mhz,
  input  wire                            rst_n,
  input  wire  [board_pkg::NUM_BTNS-1:0] btns,
  output video_pkg::pattern_e            pattern,
  output logic [board_pkg::NUM_LEDS-1:0] leds
);

  // bit 0 is next, bit 1 is prev
  logic [1:0] sync1;
  logic [1:0] sync2;
  logic [1:0] seen;
  logic [1:0] rise;
  logic [5:0] press_cnt;

  assign rise = sync2 & ~seen;

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      sync1 <= '0;
      sync2 <= '0;
      seen  <= '0;
    end else begin
      sync1 <= {btns[board_pkg::BTN_PREV], btns[board_pkg::BTN_NEXT]};
      sync2 <= sync1;
      seen  <= sync2;
    end
  end

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      pattern   <= video_pkg::PAT_BARS;
      press_cnt <= '0;
    end else begin
      unique case (rise)
        2'b01: begin
          pattern   <= video_pkg::pattern_e'(pattern + 2'd1);
          press_cnt <= press_cnt + 6'd1;
        end
        2'b10: begin
          pattern   <= video_pkg::pattern_e'(pattern - 2'd1);
          press_cnt <= press_cnt + 6'd1;
        end
        // both at once counts as no press
        default: begin
          pattern   <= pattern;
          press_cnt <= press_cnt;
        end
      endcase
    end
  end

  assign leds = {press_cnt, pattern};

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  wire                    clk_25mhz,
  input  wire                    rst_n,
  output video_pkg::vid_timing_t tim
);

  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int HS_END   = HS_START + H_SYNC;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;

  logic [10:0] hcnt;
  logic [10:0] vcnt;
  logic        line_end;
  logic        frame_end;

  assign line_end  = (hcnt == 11'(H_TOTAL - 1));
  assign frame_end = (vcnt == 11'(V_TOTAL - 1));

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (line_end) begin
      hcnt <= '0;
      vcnt <= frame_end ? 11'd0 : vcnt + 11'd1;
    end else begin
      hcnt <= hcnt + 11'd1;
    end
  end

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      tim.hs          <= 1'b1;
      tim.vs          <= 1'b1;
      tim.active      <= 1'b0;
      tim.frame_start <= 1'b0;
      tim.x           <= '0;
      tim.y           <= '0;
    end else begin
      tim.hs          <= !(hcnt >= 11'(HS_START) && hcnt < 11'(HS_END));
      tim.vs          <= !(vcnt >= 11'(VS_START) && vcnt < 11'(VS_END));
      tim.active      <= (hcnt < 11'(H_ACTIVE)) && (vcnt < 11'(V_ACTIVE));
      tim.frame_start <= (hcnt == '0) && (vcnt == '0);
      tim.x           <= hcnt;
      tim.y           <= vcnt;
    end
  end

  // x must wrap before the line total
  a_x_in_range: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n)
    tim.x < 11'(H_TOTAL)
  );

endmodule

`default_nettype wire

// ==== source/pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_gen #(
  parameter int H_ACTIVE = 640
) (
  input  wire                    clk_25mhz,
  input  wire                    rst_n,
  input  video_pkg::vid_timing_t tim,
  input  video_pkg::pattern_e    pattern,
  output video_pkg::pixel_t      pix
);

  localparam int CD = board_pkg::COLOR_DEPTH;

  video_pkg::pattern_e pat_q;
  video_pkg::pattern_e pat_now;
  logic [7:0]          frame_q;
  logic [7:0]          frame_now;
  logic                started;
  logic [13:0]         bar_full;
  logic [2:0]          bar;
  logic [10:0]         scroll_x;
  video_pkg::rgb_t     rgb;

  always_comb begin
    // new pattern and frame count take effect at pixel 0 of the frame
    pat_now   = tim.frame_start ? pattern : pat_q;
    frame_now = (tim.frame_start && started) ? frame_q + 8'd1 : frame_q;
    bar_full  = {tim.x, 3'b000} / 14'(H_ACTIVE);
    bar       = bar_full[2:0];
    scroll_x  = tim.x + {3'b000, frame_now};
    rgb       = '0;
    unique case (pat_now)
      video_pkg::PAT_BARS: begin
        rgb.r = {CD{bar[2]}};
        rgb.g = {CD{bar[1]}};
        rgb.b = {CD{bar[0]}};
      end
      video_pkg::PAT_GRAD: begin
        rgb.r = tim.x[CD-1:0];
        rgb.g = tim.y[CD-1:0];
      end
      video_pkg::PAT_CHECK: begin
        if (tim.x[3] ^ tim.y[3]) begin
          rgb = '1;
        end
      end
      video_pkg::PAT_SCROLL: begin
        rgb.r = scroll_x[CD-1:0];
        rgb.b = tim.y[CD-1:0];
      end
      default: rgb = '0;
    endcase
  end

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      pat_q   <= video_pkg::PAT_BARS;
      frame_q <= '0;
      started <= 1'b0;
      pix     <= '{hs: 1'b1, vs: 1'b1, active: 1'b0, rgb: '0};
    end else begin
      pat_q      <= pat_now;
      frame_q    <= frame_now;
      started    <= started | tim.frame_start;
      pix.hs     <= tim.hs;
      pix.vs     <= tim.vs;
      pix.active <= tim.active;
      pix.rgb    <= rgb;
    end
  end

endmodule

`default_nettype wire

// ==== source/vga_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_out (
  input  wire                            clk_25mhz,
  input  wire                            rst_n,
  input  video_pkg::pixel_t              pix,
  output logic [board_pkg::GP_WIDTH-1:0] gp
);

  localparam int CD = board_pkg::COLOR_DEPTH;

  logic            hs_q;
  logic            vs_q;
  video_pkg::rgb_t rgb_q;

  always_ff @(posedge clk_25mhz or negedge rst_n) begin
    if (!rst_n) begin
      hs_q  <= 1'b1;
      vs_q  <= 1'b1;
      rgb_q <= '0;
    end else begin
      hs_q  <= pix.hs;
      vs_q  <= pix.vs;
      // black outside the visible region
      rgb_q <= pix.active ? pix.rgb : '0;
    end
  end

  // gp header wiring, blue runs lsb first
  always_comb begin
    gp    = '0;
    gp[0] = vs_q;
    gp[1] = hs_q;
    for (int i = 0; i < CD; i++) begin
      gp[2 + i]          = rgb_q.r[CD - 1 - i];
      gp[2 + CD + i]     = rgb_q.g[CD - 1 - i];
      gp[2 + 2 * CD + i] = rgb_q.b[i];
    end
  end

  a_blank_black: assert property (
    @(posedge clk_25mhz) disable iff (!rst_n)
    !pix.active |=> (gp[2 + 3 * CD - 1:2] == '0)
  );

endmodule

`default_nettype wire

// ==== source/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top #(
  parameter int H_ACTIVE     = 640,
  parameter int H_FRONT      = 16,
  parameter int H_SYNC       = 96,
  parameter int H_BACK       = 48,
  parameter int V_ACTIVE     = 480,
  parameter int V_FRONT      = 10,
  parameter int V_SYNC       = 2,
  parameter int V_BACK       = 33,
  parameter int RESET_CYCLES = 16
) (
  input  wire                            clk_25mhz,
  input  wire                            rst_n,
  input  wire  [board_pkg::NUM_BTNS-1:0] btns,
  output logic [board_pkg::NUM_LEDS-1:0] leds,
  output logic [board_pkg::GP_WIDTH-1:0] gp
);

  logic                   design_rst_n;
  video_pkg::pattern_e    pattern;
  video_pkg::vid_timing_t tim;
  video_pkg::pixel_t      pix;

  reset_stretch #(
    .RESET_CYCLES (RESET_CYCLES)
  ) reset_stretch_i (
    .clk_25mhz    (clk_25mhz),
    .rst_n        (rst_n),
    .ready        (btns[board_pkg::BTN_READY]),
    .design_rst_n (design_rst_n)
  );

  btn_ctrl btn_ctrl_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (design_rst_n),
    .btns      (btns),
    .pattern   (pattern),
    .leds      (leds)
  );

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) video_timing_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (design_rst_n),
    .tim       (tim)
  );

  pattern_gen #(
    .H_ACTIVE (H_ACTIVE)
  ) pattern_gen_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (design_rst_n),
    .tim       (tim),
    .pattern   (pattern),
    .pix       (pix)
  );

  vga_out vga_out_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (design_rst_n),
    .pix       (pix),
    .gp        (gp)
  );

endmodule

`default_nettype wire

// ==== bench/tb_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

  localparam int H_ACTIVE     = 16;
  localparam int H_FRONT      = 2;
  localparam int H_SYNC       = 2;
  localparam int H_BACK       = 2;
  localparam int V_ACTIVE     = 8;
  localparam int V_FRONT      = 1;
  localparam int V_SYNC       = 1;
  localparam int V_BACK       = 1;
  localparam int RESET_CYCLES = 4;

  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME    = H_TOTAL * V_TOTAL;
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int VS_START = V_ACTIVE + V_FRONT;
  localparam int CD       = board_pkg::COLOR_DEPTH;
  // ready seen at a negedge, release RESET_CYCLES later, then 3 pipeline clocks
  localparam int FIRST_PIX = RESET_CYCLES + 4;
  // scripted presses land mid-frame well away from frame_start
  localparam int PRESS_AT  = 5 * H_TOTAL;

  localparam int CLK_PERIOD  = 40;
  localparam int RUN_FRAMES  = 12;
  localparam int WATCHDOG_NS = (RUN_FRAMES * FRAME + 2 * FRAME) * CLK_PERIOD;

  logic                           clk_25mhz = 1'b0;
  logic                           rst_n;
  logic [board_pkg::NUM_BTNS-1:0] btns;
  wire  [board_pkg::NUM_LEDS-1:0] leds;
  wire  [board_pkg::GP_WIDTH-1:0] gp;

  // expected button controller state
  video_pkg::pattern_e model_pat;
  logic [5:0]          model_presses;

  video_pkg::pattern_e frame_pat;
  video_pkg::rgb_t     exp_rgb;
  video_pkg::rgb_t     act_rgb;
  logic                exp_hs;
  logic                exp_vs;
  logic                prev_hs;
  logic                prev_vs;
  int                  ready_cnt;
  int                  pix_n;
  int                  px;
  int                  py;
  int                  frame_no;
  int                  last_hs_fall;
  int                  last_vs_fall;
  int                  hs_falls;
  int                  vs_falls;

  string  test_name;
  int     test_errs;
  int     err_total;
  int     tests_run;
  int     tests_failed;
  integer seed;

  board_top #(
    .H_ACTIVE     (H_ACTIVE),
    .H_FRONT      (H_FRONT),
    .H_SYNC       (H_SYNC),
    .H_BACK       (H_BACK),
    .V_ACTIVE     (V_ACTIVE),
    .V_FRONT      (V_FRONT),
    .V_SYNC       (V_SYNC),
    .V_BACK       (V_BACK),
    .RESET_CYCLES (RESET_CYCLES)
  ) dut_i (
    .clk_25mhz (clk_25mhz),
    .rst_n     (rst_n),
    .btns      (btns),
    .leds      (leds),
    .gp        (gp)
  );

  always #(CLK_PERIOD / 2) clk_25mhz = ~clk_25mhz;

  function automatic video_pkg::rgb_t expected_rgb(input video_pkg::pattern_e pat,
                                                   input int x, input int y, input int frame);
    video_pkg::rgb_t c;
    int              bar;
    int              sx;
    c   = '0;
    bar = (x * 8) / H_ACTIVE;
    // frame counter is 8 bits wide
    sx  = x + (frame % 256);
    if (x < H_ACTIVE && y < V_ACTIVE) begin
      case (pat)
        video_pkg::PAT_BARS: begin
          if (bar[2]) c.r = '1;
          if (bar[1]) c.g = '1;
          if (bar[0]) c.b = '1;
        end
        video_pkg::PAT_GRAD: begin
          c.r = x[CD-1:0];
          c.g = y[CD-1:0];
        end
        video_pkg::PAT_CHECK: begin
          if (((x / 8) + (y / 8)) % 2 == 1) c = '1;
        end
        video_pkg::PAT_SCROLL: begin
          c.r = sx[CD-1:0];
          c.b = y[CD-1:0];
        end
        default: c = '0;
      endcase
    end
    return c;
  endfunction

  function automatic video_pkg::rgb_t pins_to_rgb(input logic [board_pkg::GP_WIDTH-1:0] pins);
    video_pkg::rgb_t c;
    for (int i = 0; i < CD; i++) begin
      // r and g msb first on the header, b lsb first
      c.r[CD-1-i] = pins[2 + i];
      c.g[CD-1-i] = pins[2 + CD + i];
      c.b[i]      = pins[2 + 2 * CD + i];
    end
    return c;
  endfunction

  task automatic report_mismatch(input string what, input int exp, input int act);
    $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    test_errs = test_errs + 1;
    err_total = err_total + 1;
  endtask

  task automatic report_problem(input string what);
    $display("%s: %s", test_name, what);
    test_errs = test_errs + 1;
    err_total = err_total + 1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test;
    tests_run = tests_run + 1;
    if (test_errs == 0) begin
      $display("test %s passed", test_name);
    end else begin
      $display("test %s failed with %0d errors", test_name, test_errs);
      tests_failed = tests_failed + 1;
    end
  endtask

  task automatic wait_for_pixel(input int target);
    do begin
      @(posedge clk_25mhz);
    end while (pix_n < target);
  endtask

  task automatic press_button(input int idx, input int hold);
    btns[idx] <= 1'b1;
    repeat (hold) @(posedge clk_25mhz);
    btns[idx] <= 1'b0;
    if (idx == board_pkg::BTN_NEXT) begin
      model_pat = video_pkg::pattern_e'((int'(model_pat) + 1) % 4);
    end else begin
      model_pat = video_pkg::pattern_e'((int'(model_pat) + 3) % 4);
    end
    model_presses = model_presses + 6'd1;
    repeat (5) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    if (leds !== {model_presses, model_pat}) begin
      report_mismatch("leds after press", int'({model_presses, model_pat}), int'(leds));
    end
  endtask

  // compares the pins against the raster position at every pixel
  always @(negedge clk_25mhz) begin
    if (btns[board_pkg::BTN_READY] === 1'b1) ready_cnt = ready_cnt + 1;
    pix_n   = ready_cnt - FIRST_PIX;
    act_rgb = pins_to_rgb(gp);
    if (pix_n < 0) begin
      if (gp[1:0] !== 2'b11) report_mismatch("idle syncs", 3, int'(gp[1:0]));
      if (act_rgb !== '0) report_mismatch("idle colour", 0, int'(act_rgb));
      if (leds !== '0) report_mismatch("idle leds", 0, int'(leds));
    end else begin
      px       = pix_n % H_TOTAL;
      py       = (pix_n / H_TOTAL) % V_TOTAL;
      frame_no = pix_n / FRAME;
      if (pix_n % FRAME == 0) frame_pat = model_pat;
      exp_hs  = !(px >= HS_START && px < HS_START + H_SYNC);
      exp_vs  = !(py >= VS_START && py < VS_START + V_SYNC);
      exp_rgb = expected_rgb(frame_pat, px, py, frame_no);
      if (gp[1] !== exp_hs) report_mismatch("hs level", int'(exp_hs), int'(gp[1]));
      if (gp[0] !== exp_vs) report_mismatch("vs level", int'(exp_vs), int'(gp[0]));
      if (act_rgb !== exp_rgb) report_mismatch("pixel colour", int'(exp_rgb), int'(act_rgb));
      if (gp[27:20] !== '0) report_mismatch("unused gp pins", 0, int'(gp[27:20]));
      if (prev_hs && !gp[1]) begin
        hs_falls = hs_falls + 1;
        if (px != HS_START) report_mismatch("x at hs fall", HS_START, px);
        if (last_hs_fall >= 0 && pix_n - last_hs_fall != H_TOTAL) begin
          report_mismatch("hs period", H_TOTAL, pix_n - last_hs_fall);
        end
        last_hs_fall = pix_n;
      end
      if (!prev_hs && gp[1] && pix_n - last_hs_fall != H_SYNC) begin
        report_mismatch("hs low width", H_SYNC, pix_n - last_hs_fall);
      end
      if (prev_vs && !gp[0]) begin
        vs_falls = vs_falls + 1;
        if (py != VS_START || px != 0) report_mismatch("line at vs fall", VS_START, py);
        if (last_vs_fall >= 0 && pix_n - last_vs_fall != FRAME) begin
          report_mismatch("vs period", FRAME, pix_n - last_vs_fall);
        end
        last_vs_fall = pix_n;
      end
      if (!prev_vs && gp[0] && pix_n - last_vs_fall != V_SYNC * H_TOTAL) begin
        report_mismatch("vs low width", V_SYNC * H_TOTAL, pix_n - last_vs_fall);
      end
    end
    prev_hs = gp[1];
    prev_vs = gp[0];
  end

  initial begin
    int gap;
    int hold;
    int pick;
    rst_n         = 1'b0;
    btns          = '0;
    model_pat     = video_pkg::PAT_BARS;
    model_presses = '0;
    frame_pat     = video_pkg::PAT_BARS;
    ready_cnt     = 0;
    pix_n         = -FIRST_PIX;
    prev_hs       = 1'b1;
    prev_vs       = 1'b1;
    last_hs_fall  = -1;
    last_vs_fall  = -1;
    hs_falls      = 0;
    vs_falls      = 0;
    err_total     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    seed          = 32'h1bb0_c55d;

    start_test("reset_idle");
    repeat (16) @(posedge clk_25mhz);
    rst_n <= 1'b1;
    repeat (10) @(posedge clk_25mhz);
    btns[board_pkg::BTN_READY] <= 1'b1;
    wait_for_pixel(0);
    end_test();

    start_test("bars_blank");
    wait_for_pixel(FRAME);
    end_test();

    start_test("sync_timing");
    wait_for_pixel(2 * FRAME);
    if (hs_falls < 2 * V_TOTAL) report_problem("too few hs falling edges in two frames");
    if (vs_falls < 2) report_problem("no full vs period was seen in two frames");
    end_test();

    start_test("next_button");
    wait_for_pixel(2 * FRAME + PRESS_AT);
    press_button(board_pkg::BTN_NEXT, 3);
    wait_for_pixel(3 * FRAME + PRESS_AT);
    press_button(board_pkg::BTN_NEXT, 2);
    wait_for_pixel(4 * FRAME + PRESS_AT);
    end_test();

    // scroll shows in frames 5 to 7
    start_test("scroll");
    press_button(board_pkg::BTN_NEXT, 4);
    wait_for_pixel(8 * FRAME);
    end_test();

    start_test("prev_wrap");
    wait_for_pixel(8 * FRAME + PRESS_AT);
    press_button(board_pkg::BTN_NEXT, 2);
    wait_for_pixel(9 * FRAME + PRESS_AT);
    press_button(board_pkg::BTN_PREV, 2);
    if (leds[1:0] !== 2'd3) report_mismatch("prev from bars", 3, int'(leds[1:0]));
    wait_for_pixel(10 * FRAME + H_TOTAL);
    for (int k = 0; k < 4; k++) begin
      gap  = 1 + ($unsigned($random(seed)) % 16);
      hold = 1 + ($unsigned($random(seed)) % 6);
      pick = $unsigned($random(seed)) % 2;
      repeat (gap) @(posedge clk_25mhz);
      press_button(pick == 1 ? board_pkg::BTN_PREV : board_pkg::BTN_NEXT, hold);
    end
    wait_for_pixel(12 * FRAME);
    end_test();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the last test ended");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/board_pkg.sv
source/video_pkg.sv
source/reset_stretch.sv
source/btn_ctrl.sv
source/video_timing.sv
source/pattern_gen.sv
source/vga_out.sv
source/board_top.sv
bench/tb_board_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_board_top \
  -f files.f

out="$(./obj_dir/Vtb_board_top 2>&1)" || true
echo "$out"

# the exit status of grep decides pass or fail
grep -qx "Finished with no errors" <<< "$out"
